/* source/hk_pkg.sv */
// housekeeping MMIO package
// widths, register offsets, state enums and bus/pad structs
package hk_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;
  typedef logic [15:0] gpio_t;
  typedef logic [7:0]  offset_t;
  typedef logic [31:0] irq_vec_t;
  // 0 = none, 1..3 = first..third candidate pad
  typedef logic [1:0]  irq_src_t;

  typedef enum logic [1:0] {
    PLL_OFF  = 2'd0,
    PLL_PAD8 = 2'd1,
    PLL_PAD9 = 2'd2
  } pll_dest_e;

  typedef enum logic [1:0] {
    TRAP_OFF   = 2'd0,
    TRAP_PAD11 = 2'd1,
    TRAP_PAD12 = 2'd2,
    TRAP_PAD13 = 2'd3
  } trap_dest_e;

  typedef enum logic {
    IDLE = 1'b0,
    ACK  = 1'b1
  } bus_fsm_e;

  // register page layout
  localparam offset_t OFS_GPIO      = 8'h00;
  localparam offset_t OFS_OEB       = 8'h04;
  localparam offset_t OFS_PU        = 8'h08;
  localparam offset_t OFS_PD        = 8'h0c;
  localparam offset_t OFS_CONFIG    = 8'h18;
  localparam offset_t OFS_ENA       = 8'h1c;
  localparam offset_t OFS_PLL       = 8'h20;
  localparam offset_t OFS_MFGR      = 8'h24;
  localparam offset_t OFS_PROD      = 8'h28;
  localparam offset_t OFS_MASK      = 8'h2c;
  localparam offset_t OFS_CLKSEL    = 8'h30;
  localparam offset_t OFS_PLL_DEST  = 8'h38;
  localparam offset_t OFS_TRAP_DEST = 8'h3c;
  localparam offset_t OFS_IRQ7_SRC  = 8'h40;
  localparam offset_t OFS_IRQ8_SRC  = 8'h44;

  typedef struct packed {
    logic  valid;
    word_t addr;
    word_t wdata;
    strb_t wstrb;
  } bus_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } bus_rsp_t;

  typedef struct packed {
    gpio_t      gpio;
    gpio_t      oeb;
    gpio_t      pu;
    gpio_t      pd;
    pll_dest_e  pll_dest;
    trap_dest_e trap_dest;
    irq_src_t   irq7_src;
    irq_src_t   irq8_src;
  } ctrl_regs_t;

  typedef struct packed {
    gpio_t out;
    gpio_t outenb;
    gpio_t pullupb;
    gpio_t pulldownb;
  } pad_ctrl_t;

  // read-only values from the housekeeping SPI
  typedef struct packed {
    logic [7:0]  cfg;
    logic        xtal_ena;
    logic        reg_ena;
    logic        pll_cp_ena;
    logic        pll_vco_ena;
    logic        pll_bias_ena;
    logic [3:0]  pll_trim;
    logic [11:0] mfgr_id;
    logic [7:0]  prod_id;
    logic [3:0]  mask_rev;
    logic        clk_ext_sel;
  } strap_t;

endpackage

/* source/hk_bus_fsm.sv */
// bus response FSM for the housekeeping page
// accepts one request, strobes the write, returns registered read data
`timescale 1ns/1ps

module hk_bus_fsm #(
  parameter logic [23:0] PAGE_BASE = 24'h030000
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  hk_pkg::bus_req_t req_i,
  input  hk_pkg::word_t    rd_word_i,
  output hk_pkg::strb_t    reg_we_o,
  output hk_pkg::bus_rsp_t rsp_o
);
  import hk_pkg::*;

  bus_fsm_e state_q;
  logic     page_hit;
  logic     accept;

  assign page_hit = (req_i.addr[31:8] == PAGE_BASE);
  // out-of-page requests stay unanswered
  assign accept   = (state_q == IDLE) && req_i.valid && page_hit;

  assign reg_we_o = accept ? req_i.wstrb : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      rsp_o.ready <= 1'b0;
      rsp_o.rdata <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q     <= ACK;
            rsp_o.ready <= 1'b1;
            // value before the write lands
            rsp_o.rdata <= rd_word_i;
          end
        end
        ACK: begin
          state_q     <= IDLE;
          rsp_o.ready <= 1'b0;
        end
        default: begin
          state_q     <= IDLE;
          rsp_o.ready <= 1'b0;
        end
      endcase
    end
  end

endmodule

/* source/hk_ctrl_regs.sv */
// writable GPIO, pin routing and irq select registers
// GPIO registers take byte-lane writes on lanes 0 and 1
`timescale 1ns/1ps

module hk_ctrl_regs (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  hk_pkg::offset_t    offset_i,
  input  hk_pkg::word_t      wdata_i,
  input  hk_pkg::strb_t      we_i,
  output hk_pkg::ctrl_regs_t regs_o
);
  import hk_pkg::*;

  ctrl_regs_t regs_q;

  // merge the enabled low two byte lanes into a 16-bit register
  function automatic gpio_t lane_write(gpio_t cur, word_t wd, strb_t we);
    gpio_t res;
    res = cur;
    if (we[0]) begin
      res[7:0] = wd[7:0];
    end
    if (we[1]) begin
      res[15:8] = wd[15:8];
    end
    return res;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      regs_q.gpio      <= '0;
      regs_q.oeb       <= '1;
      regs_q.pu        <= '0;
      regs_q.pd        <= '0;
      regs_q.pll_dest  <= PLL_OFF;
      regs_q.trap_dest <= TRAP_OFF;
      regs_q.irq7_src  <= '0;
      regs_q.irq8_src  <= '0;
    end else if (we_i != '0) begin
      case (offset_i)
        OFS_GPIO: regs_q.gpio <= lane_write(regs_q.gpio, wdata_i, we_i);
        OFS_OEB:  regs_q.oeb  <= lane_write(regs_q.oeb, wdata_i, we_i);
        OFS_PU:   regs_q.pu   <= lane_write(regs_q.pu, wdata_i, we_i);
        OFS_PD:   regs_q.pd   <= lane_write(regs_q.pd, wdata_i, we_i);
        OFS_PLL_DEST: begin
          if (we_i[0]) begin
            regs_q.pll_dest <= pll_dest_e'(wdata_i[1:0]);
          end
        end
        OFS_TRAP_DEST: begin
          if (we_i[0]) begin
            regs_q.trap_dest <= trap_dest_e'(wdata_i[1:0]);
          end
        end
        OFS_IRQ7_SRC: begin
          if (we_i[0]) begin
            regs_q.irq7_src <= wdata_i[1:0];
          end
        end
        OFS_IRQ8_SRC: begin
          if (we_i[0]) begin
            regs_q.irq8_src <= wdata_i[1:0];
          end
        end
        default: ;
      endcase
    end
  end

  assign regs_o = regs_q;

endmodule

/* source/hk_read_mux.sv */
// read word select for the housekeeping page
`timescale 1ns/1ps

module hk_read_mux (
  input  hk_pkg::offset_t    offset_i,
  input  hk_pkg::ctrl_regs_t regs_i,
  input  hk_pkg::pad_ctrl_t  pad_i,
  input  hk_pkg::gpio_t      gpio_in_i,
  input  hk_pkg::strap_t     strap_i,
  output hk_pkg::word_t      rd_word_o
);
  import hk_pkg::*;

  always_comb begin
    case (offset_i)
      // driven pad values above, sampled inputs below
      OFS_GPIO:   rd_word_o = {pad_i.out, gpio_in_i};
      OFS_OEB:    rd_word_o = {16'd0, regs_i.oeb};
      OFS_PU:     rd_word_o = {16'd0, regs_i.pu};
      OFS_PD:     rd_word_o = {16'd0, regs_i.pd};
      OFS_CONFIG: rd_word_o = {24'd0, strap_i.cfg};
      OFS_ENA:    rd_word_o = {30'd0, strap_i.xtal_ena, strap_i.reg_ena};
      OFS_PLL: begin
        rd_word_o = {
          25'd0,
          strap_i.pll_trim,
          strap_i.pll_cp_ena,
          strap_i.pll_vco_ena,
          strap_i.pll_bias_ena
        };
      end
      OFS_MFGR:      rd_word_o = {20'd0, strap_i.mfgr_id};
      OFS_PROD:      rd_word_o = {24'd0, strap_i.prod_id};
      OFS_MASK:      rd_word_o = {28'd0, strap_i.mask_rev};
      OFS_CLKSEL:    rd_word_o = {31'd0, strap_i.clk_ext_sel};
      OFS_PLL_DEST:  rd_word_o = {30'd0, regs_i.pll_dest};
      OFS_TRAP_DEST: rd_word_o = {30'd0, regs_i.trap_dest};
      OFS_IRQ7_SRC:  rd_word_o = {30'd0, regs_i.irq7_src};
      OFS_IRQ8_SRC:  rd_word_o = {30'd0, regs_i.irq8_src};
      default:       rd_word_o = '0;
    endcase
  end

endmodule

/* source/hk_pad_mux.sv */
// GPIO pad drive with clock and trap routing
// also builds the irq vector from the pins owned here
`timescale 1ns/1ps

module hk_pad_mux (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  hk_pkg::ctrl_regs_t regs_i,
  input  hk_pkg::gpio_t      gpio_in_i,
  input  logic               trap_i,
  input  logic               irq_pin_i,
  input  logic               irq_spi_i,
  output hk_pkg::pad_ctrl_t  pad_o,
  output hk_pkg::irq_vec_t   irq_o
);
  import hk_pkg::*;

  // pick one of three candidate pads, none when sel is 0
  function automatic logic irq_pick(irq_src_t sel, logic [2:0] cand);
    logic res;
    case (sel)
      2'd1:    res = cand[0];
      2'd2:    res = cand[1];
      2'd3:    res = cand[2];
      default: res = 1'b0;
    endcase
    return res;
  endfunction

  always_comb begin
    pad_o.out       = regs_i.gpio;
    pad_o.outenb    = regs_i.oeb;
    pad_o.pullupb   = regs_i.pu;
    pad_o.pulldownb = regs_i.pd;

    // clock out takes pads 8..10
    if (regs_i.pll_dest != PLL_OFF) begin
      pad_o.outenb[10:8]    = 3'b000;
      pad_o.pullupb[10:8]   = 3'b111;
      pad_o.pulldownb[10:8] = 3'b111;
    end
    if (regs_i.pll_dest == PLL_PAD8) begin
      pad_o.out[8] = clk_i;
    end
    if (regs_i.pll_dest == PLL_PAD9) begin
      pad_o.out[9] = clk_i;
    end

    // trap out takes pads 11..13
    if (regs_i.trap_dest != TRAP_OFF) begin
      pad_o.outenb[13:11]    = 3'b000;
      pad_o.pullupb[13:11]   = 3'b111;
      pad_o.pulldownb[13:11] = 3'b111;
    end
    case (regs_i.trap_dest)
      TRAP_PAD11: pad_o.out[11] = trap_i;
      TRAP_PAD12: pad_o.out[12] = trap_i;
      TRAP_PAD13: pad_o.out[13] = trap_i;
      default: ;
    endcase

    // no pad drives during reset
    if (!rst_n_i) begin
      pad_o.outenb = '1;
    end
  end

  always_comb begin
    irq_o    = '0;
    irq_o[5] = irq_pin_i;
    irq_o[6] = irq_spi_i;
    irq_o[7] = irq_pick(regs_i.irq7_src, gpio_in_i[2:0]);
    irq_o[8] = irq_pick(regs_i.irq8_src, gpio_in_i[5:3]);
  end

endmodule

/* source/hk_mmio_top.sv */
// housekeeping MMIO block top level
// native bus in, GPIO pads and irq vector out
`timescale 1ns/1ps

module hk_mmio_top #(
  parameter logic [23:0] PAGE_BASE = 24'h030000
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  hk_pkg::bus_req_t  req_i,
  output hk_pkg::bus_rsp_t  rsp_o,
  input  hk_pkg::gpio_t     gpio_in_i,
  input  hk_pkg::strap_t    strap_i,
  input  logic              trap_i,
  input  logic              irq_pin_i,
  input  logic              irq_spi_i,
  output hk_pkg::pad_ctrl_t pad_o,
  output hk_pkg::irq_vec_t  irq_o
);
  import hk_pkg::*;

  strb_t      reg_we;
  word_t      rd_word;
  ctrl_regs_t regs;

  hk_bus_fsm #(
    .PAGE_BASE(PAGE_BASE)
  ) u_bus_fsm (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (req_i),
    .rd_word_i(rd_word),
    .reg_we_o (reg_we),
    .rsp_o    (rsp_o)
  );

  hk_ctrl_regs u_ctrl_regs (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .offset_i(req_i.addr[7:0]),
    .wdata_i (req_i.wdata),
    .we_i    (reg_we),
    .regs_o  (regs)
  );

  // GPIO reads see the pads as driven
  hk_read_mux u_read_mux (
    .offset_i (req_i.addr[7:0]),
    .regs_i   (regs),
    .pad_i    (pad_o),
    .gpio_in_i(gpio_in_i),
    .strap_i  (strap_i),
    .rd_word_o(rd_word)
  );

  hk_pad_mux u_pad_mux (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .regs_i   (regs),
    .gpio_in_i(gpio_in_i),
    .trap_i   (trap_i),
    .irq_pin_i(irq_pin_i),
    .irq_spi_i(irq_spi_i),
    .pad_o    (pad_o),
    .irq_o    (irq_o)
  );

endmodule

/* test/hk_checker.sv */
// checker for the housekeeping MMIO block
// compares read data, pad drive and irq lines against its own register model
`timescale 1ns/1ps

module hk_checker (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  hk_pkg::bus_req_t  req_i,
  input  hk_pkg::bus_rsp_t  rsp_i,
  input  hk_pkg::word_t     exp_i,
  input  hk_pkg::gpio_t     gpio_in_i,
  input  logic              trap_i,
  input  logic              irq_pin_i,
  input  logic              irq_spi_i,
  input  hk_pkg::pad_ctrl_t pad_i,
  input  hk_pkg::irq_vec_t  irq_i,
  output int                read_errs_o = 0,
  output int                pad_errs_o = 0,
  output int                irq_errs_o = 0
);
  import hk_pkg::*;

  bus_req_t   req_q;
  word_t      exp_q;
  gpio_t      m_gpio;
  gpio_t      m_oeb;
  gpio_t      m_pu;
  gpio_t      m_pd;
  logic [1:0] m_pll;
  logic [1:0] m_trap;
  logic [1:0] m_irq7;
  logic [1:0] m_irq8;
  pad_ctrl_t  exp_pad;
  irq_vec_t   exp_irq;
  logic [2:0] cand7;
  logic [2:0] cand8;
  logic       ready_prev = 1'b0;
  logic       exp_ready;

  function automatic gpio_t merge_lanes(gpio_t cur, word_t wd, strb_t st);
    gpio_t res;
    res = cur;
    if (st[0]) res[7:0] = wd[7:0];
    if (st[1]) res[15:8] = wd[15:8];
    return res;
  endfunction

  task automatic update_model();
    case (req_q.addr[7:0])
      8'h00: m_gpio = merge_lanes(m_gpio, req_q.wdata, req_q.wstrb);
      8'h04: m_oeb = merge_lanes(m_oeb, req_q.wdata, req_q.wstrb);
      8'h08: m_pu = merge_lanes(m_pu, req_q.wdata, req_q.wstrb);
      8'h0c: m_pd = merge_lanes(m_pd, req_q.wdata, req_q.wstrb);
      8'h38: if (req_q.wstrb[0]) m_pll = req_q.wdata[1:0];
      8'h3c: if (req_q.wstrb[0]) m_trap = req_q.wdata[1:0];
      8'h40: if (req_q.wstrb[0]) m_irq7 = req_q.wdata[1:0];
      8'h44: if (req_q.wstrb[0]) m_irq8 = req_q.wdata[1:0];
      default: ;
    endcase
  endtask

  // request as the DUT saw it at the rising edge
  always @(posedge clk_i) begin
    req_q <= req_i;
    exp_q <= exp_i;
  end

  always @(negedge clk_i) begin
    #25;
    if (!rst_n_i) begin
      m_gpio     = '0;
      m_oeb      = '1;
      m_pu       = '0;
      m_pd       = '0;
      m_pll      = '0;
      m_trap     = '0;
      m_irq7     = '0;
      m_irq8     = '0;
      ready_prev = 1'b0;
    end else begin
      // accept needs an idle FSM and ready follows one cycle later
      exp_ready = req_q.valid && !ready_prev;
      if (rsp_i.ready !== exp_ready) begin
        $display("FAILED at %0d ns: ready was %0b, expected %0b",
                 $time, rsp_i.ready, exp_ready);
        read_errs_o++;
      end
      ready_prev = rsp_i.ready;
      if (rsp_i.ready) begin
        if (rsp_i.rdata !== exp_q) begin
          $display("FAILED at %0d ns: read of offset %02h gave %08h, expected %08h",
                   $time, req_q.addr[7:0], rsp_i.rdata, exp_q);
          read_errs_o++;
        end
        if (req_q.wstrb != '0) update_model();
      end
      exp_pad = '{out: m_gpio, outenb: m_oeb, pullupb: m_pu, pulldownb: m_pd};
      if (m_pll != 2'd0) begin
        exp_pad.outenb[10:8]    = '0;
        exp_pad.pullupb[10:8]   = '1;
        exp_pad.pulldownb[10:8] = '1;
        // clock is low at this sample point
        if (m_pll == 2'd1) exp_pad.out[8] = 1'b0;
        if (m_pll == 2'd2) exp_pad.out[9] = 1'b0;
      end
      if (m_trap != 2'd0) begin
        exp_pad.outenb[13:11]    = '0;
        exp_pad.pullupb[13:11]   = '1;
        exp_pad.pulldownb[13:11] = '1;
        exp_pad.out[4'd10 + {2'b00, m_trap}] = trap_i;
      end
      if (pad_i !== exp_pad) begin
        $display("FAILED at %0d ns: pads gave %016h, expected %016h", $time, pad_i, exp_pad);
        pad_errs_o++;
      end
      cand7 = gpio_in_i[2:0];
      cand8 = gpio_in_i[5:3];
      exp_irq    = '0;
      exp_irq[5] = irq_pin_i;
      exp_irq[6] = irq_spi_i;
      exp_irq[7] = (m_irq7 == 2'd0) ? 1'b0 : cand7[m_irq7 - 2'd1];
      exp_irq[8] = (m_irq8 == 2'd0) ? 1'b0 : cand8[m_irq8 - 2'd1];
      if (irq_i !== exp_irq) begin
        $display("FAILED at %0d ns: irq vector gave %08h, expected %08h", $time, irq_i, exp_irq);
        irq_errs_o++;
      end
    end
  end

endmodule

/* test/tb_hk_mmio.sv */
// testbench for the housekeeping MMIO block
// reads bus operations from a file and drives them on the native bus
`timescale 1ns/1ps

module tb_hk_mmio;
  import hk_pkg::*;

  typedef struct packed {
    logic [7:0] op;
    offset_t    ofs;
    word_t      wdata;
    strb_t      wstrb;
    gpio_t      gpio_in;
    logic       trap;
    word_t      exp;
  } test_t;

  localparam logic [23:0] PAGE = 24'h030000;

  logic      clk;
  logic      rst_n;
  bus_req_t  req;
  bus_rsp_t  rsp;
  gpio_t     gpio_in;
  strap_t    strap;
  logic      trap;
  logic      irq_pin;
  logic      irq_spi;
  pad_ctrl_t pad;
  irq_vec_t  irq;
  word_t     exp_word;
  test_t     tests[$];
  int        cycles = 0;
  int        cycle_limit = 0;
  int        timeout_errs = 0;
  int        read_errs;
  int        pad_errs;
  int        irq_errs;

  hk_mmio_top #(
    .PAGE_BASE(PAGE)
  ) dut (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .req_i    (req),
    .rsp_o    (rsp),
    .gpio_in_i(gpio_in),
    .strap_i  (strap),
    .trap_i   (trap),
    .irq_pin_i(irq_pin),
    .irq_spi_i(irq_spi),
    .pad_o    (pad),
    .irq_o    (irq)
  );

  hk_checker u_checker (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_i      (req),
    .rsp_i      (rsp),
    .exp_i      (exp_word),
    .gpio_in_i  (gpio_in),
    .trap_i     (trap),
    .irq_pin_i  (irq_pin),
    .irq_spi_i  (irq_spi),
    .pad_i      (pad),
    .irq_i      (irq),
    .read_errs_o(read_errs),
    .pad_errs_o (pad_errs),
    .irq_errs_o (irq_errs)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("run stopped at the cycle limit of %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic load_tests(output bit ok);
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    offset_t    ofs;
    word_t      wd;
    strb_t      st;
    gpio_t      gi;
    logic       tr;
    word_t      ex;
    fd = $fopen("test/hk_tests.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // skip blank and comment lines
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h %h %h %h %h", op, ofs, wd, st, gi, tr, ex);
          if (n == 7) begin
            tests.push_back('{op, ofs, wd, st, gi, tr, ex});
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // called on a falling edge, returns on the falling edge where ready shows
  task automatic run_op(int idx);
    test_t t;
    int    waited;
    t = tests[idx];
    req.valid = 1'b1;
    req.addr  = {PAGE, t.ofs};
    req.wdata = t.wdata;
    req.wstrb = (t.op == "R") ? '0 : t.wstrb;
    gpio_in   = t.gpio_in;
    trap      = t.trap;
    irq_pin   = t.gpio_in[15];
    irq_spi   = t.gpio_in[14];
    exp_word  = t.exp;
    waited    = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!rsp.ready && waited < 4);
    if (!rsp.ready) begin
      $display("timeout: no ready within 4 cycles for test line %0d", idx + 1);
      timeout_errs++;
    end
  endtask

  initial begin
    bit ok;
    int total;
    rst_n    = 1'b0;
    req      = '0;
    gpio_in  = '0;
    trap     = 1'b0;
    irq_pin  = 1'b0;
    irq_spi  = 1'b0;
    exp_word = '0;
    strap = '{cfg: 8'ha5, xtal_ena: 1'b1, reg_ena: 1'b0, pll_cp_ena: 1'b1,
              pll_vco_ena: 1'b0, pll_bias_ena: 1'b1, pll_trim: 4'h9,
              mfgr_id: 12'h456, prod_id: 8'h10, mask_rev: 4'h3, clk_ext_sel: 1'b1};
    load_tests(ok);
    if (!ok) begin
      $display("cannot open the test file test/hk_tests.txt");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      cycle_limit = 10 + 4 * tests.size();
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      foreach (tests[i]) begin
        run_op(i);
      end
      req.valid = 1'b0;
      repeat (2) @(negedge clk);
      total = read_errs + pad_errs + irq_errs + timeout_errs;
      $display("errors: read %0d, pad %0d, irq %0d, timeout %0d",
               read_errs, pad_errs, irq_errs, timeout_errs);
      if (total == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

/* test/hk_tests.txt */
# op offset wdata wstrb gpio_in trap expected_read, all hex
# a write returns the word read before the write lands
R 00 00000000 0 1234 0 00001234
R 04 00000000 0 0000 0 0000ffff
R 0c 00000000 0 0000 0 00000000
R 3c 00000000 0 0000 0 00000000
W 00 0000a55a 1 0000 0 00000000
W 00 0000c3c3 2 0000 0 005a0000
W 04 00001234 1 0000 0 0000ffff
W 08 00005678 3 0000 0 00000000
W 0c 00009abc 2 0000 0 00000000
W 0c 0000ffde 1 0000 0 00009a00
R 0c 00000000 0 0000 0 00009ade
W 08 ffffffff c 0000 0 00005678
R 04 00000000 0 0000 0 0000ff34
R 18 00000000 0 0000 0 000000a5
R 20 00000000 0 0000 0 0000004d
R 24 00000000 0 0000 0 00000456
R 30 00000000 0 0000 0 00000001
R fc 00000000 0 0000 0 00000000
W 3c 00000001 1 0000 1 00000000
R 00 00000000 0 0000 1 cb5a0000
W 3c 00000003 1 0000 1 00000001
R 00 00000000 0 0000 1 e35a0000
W 3c 00000000 1 0000 0 00000003
W 38 00000001 1 0000 0 00000000
W 38 00000002 1 0000 0 00000001
W 38 00000000 1 0000 0 00000002
W 40 00000002 1 0002 0 00000000
W 44 00000003 1 0020 0 00000000
R 44 00000000 0 c005 0 00000003
R 00 00000000 0 0000 0 c35a0000

/* all.f */
source/hk_pkg.sv
source/hk_bus_fsm.sv
source/hk_ctrl_regs.sv
source/hk_read_mux.sv
source/hk_pad_mux.sv
source/hk_mmio_top.sv
test/hk_checker.sv
test/tb_hk_mmio.sv

/* Makefile */
# Verilator build and run for the housekeeping MMIO testbench

TOP = tb_hk_mmio
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f all.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "ALL CHECKS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
